// File: hw/harness_pkg.sv
/*
 * Harness package
 * DMI channel widths and codes, the peripheral address map of the
 * system bus and the length of the hart debug request hold-off.
 */
`default_nettype none

package harness_pkg;

  // ----------------------------------------------------------------------
  // Debug module interface
  // ----------------------------------------------------------------------
  localparam int unsigned DmiAddrWidth = 7;
  localparam int unsigned DmiDataWidth = 32;

  typedef enum logic [1:0] {
    DMI_NOP   = 2'h0,
    DMI_READ  = 2'h1,
    DMI_WRITE = 2'h2
  } dmi_op_e;

  // Code 1 is reserved by the debug spec
  typedef enum logic [1:0] {
    DMI_SUCCESS = 2'h0,
    DMI_FAILED  = 2'h2,
    DMI_BUSY    = 2'h3
  } dmi_resp_e;

  // ----------------------------------------------------------------------
  // System address map
  // ----------------------------------------------------------------------
  localparam int unsigned SysAddrWidth = 64;
  localparam int unsigned NumPeriph    = 10;

  // Map order, also the index into the base and length tables
  typedef enum logic [3:0] {
    DEBUG    = 4'd0,
    ROM      = 4'd1,
    CLINT    = 4'd2,
    PLIC     = 4'd3,
    UART     = 4'd4,
    TIMER    = 4'd5,
    SPI      = 4'd6,
    ETHERNET = 4'd7,
    GPIO     = 4'd8,
    DRAM     = 4'd9
  } periph_e;

  localparam logic [SysAddrWidth-1:0] PeriphBase [NumPeriph] = '{
    64'h0000_0000, 64'h0001_0000, 64'h0200_0000, 64'h0C00_0000, 64'h1000_0000,
    64'h1800_0000, 64'h2000_0000, 64'h3000_0000, 64'h4000_0000, 64'h8000_0000
  };

  // DRAM region is 1 GiB
  localparam logic [SysAddrWidth-1:0] PeriphLength [NumPeriph] = '{
    64'h0000_1000, 64'h0001_0000, 64'h000C_0000, 64'h03FF_FFFF, 64'h0000_1000,
    64'h0000_1000, 64'h0080_0000, 64'h0001_0000, 64'h0000_1000, 64'h4000_0000
  };

  // ----------------------------------------------------------------------
  // Debug request hold-off
  // ----------------------------------------------------------------------
  // Gives the boot code time to set up a0/a1 before the first halt
  localparam int unsigned HoldoffCycles = 500;
  localparam int unsigned HoldoffWidth  = $clog2(HoldoffCycles + 1);

endpackage

`default_nettype wire

// File: hw/dmi_if.sv
/*
 * DMI channel
 * One request/response channel between a debug transport and the
 * debug module, valid/ready handshake on both directions.
 */
`timescale 1ns/1ps
`default_nettype none

interface dmi_if import harness_pkg::*; ();

  // Request, source to target
  logic                    req_valid;
  logic                    req_ready;
  logic [DmiAddrWidth-1:0] req_addr;
  dmi_op_e                 req_op;
  logic [DmiDataWidth-1:0] req_data;

  // Response, target to source
  logic                    resp_valid;
  logic                    resp_ready;
  logic [DmiDataWidth-1:0] resp_data;
  dmi_resp_e               resp_code;

  modport source (
    output req_valid,
    output req_addr,
    output req_op,
    output req_data,
    output resp_ready,
    input  req_ready,
    input  resp_valid,
    input  resp_data,
    input  resp_code
  );

  modport target (
    input  req_valid,
    input  req_addr,
    input  req_op,
    input  req_data,
    input  resp_ready,
    output req_ready,
    output resp_valid,
    output resp_data,
    output resp_code
  );

endinterface

`default_nettype wire

// File: hw/dmi_source_mux.sv
/*
 * DMI source mux
 * Puts either the JTAG or the DTM transport on the debug module port.
 * Only the selected source sees the response strobe, and the same
 * select picks the exit code reported by the harness.
 */
`timescale 1ns/1ps
`default_nettype none

module dmi_source_mux import harness_pkg::*; (
  input  logic                    jtag_sel_i,
  dmi_if.target                   jtag_dmi,
  dmi_if.target                   dtm_dmi,
  dmi_if.source                   dm_dmi,
  input  logic [DmiDataWidth-1:0] jtag_exit_i,
  input  logic [DmiDataWidth-1:0] dtm_exit_i,
  output logic [DmiDataWidth-1:0] exit_o
);

  // ----------------------------------------------------------------------
  // Request path
  // ----------------------------------------------------------------------
  always_comb begin
    if (jtag_sel_i) begin
      dm_dmi.req_valid  = jtag_dmi.req_valid;
      dm_dmi.req_addr   = jtag_dmi.req_addr;
      dm_dmi.req_op     = jtag_dmi.req_op;
      dm_dmi.req_data   = jtag_dmi.req_data;
      dm_dmi.resp_ready = jtag_dmi.resp_ready;
    end else begin
      dm_dmi.req_valid  = dtm_dmi.req_valid;
      dm_dmi.req_addr   = dtm_dmi.req_addr;
      dm_dmi.req_op     = dtm_dmi.req_op;
      dm_dmi.req_data   = dtm_dmi.req_data;
      dm_dmi.resp_ready = dtm_dmi.resp_ready;
    end
  end

  // ----------------------------------------------------------------------
  // Response path
  // ----------------------------------------------------------------------
  // Back-pressure and payload go to both sources
  assign jtag_dmi.req_ready = dm_dmi.req_ready;
  assign dtm_dmi.req_ready  = dm_dmi.req_ready;
  assign jtag_dmi.resp_data = dm_dmi.resp_data;
  assign dtm_dmi.resp_data  = dm_dmi.resp_data;
  assign jtag_dmi.resp_code = dm_dmi.resp_code;
  assign dtm_dmi.resp_code  = dm_dmi.resp_code;

  // Idle source must not see a response it never asked for
  assign jtag_dmi.resp_valid = jtag_sel_i & dm_dmi.resp_valid;
  assign dtm_dmi.resp_valid  = ~jtag_sel_i & dm_dmi.resp_valid;

  // Exit code follows the active transport
  assign exit_o = jtag_sel_i ? jtag_exit_i : dtm_exit_i;

endmodule

`default_nettype wire

// File: hw/debug_req_holdoff.sv
/*
 * Debug request hold-off
 * Blocks the hart debug request for a fixed time after power-on reset
 * and whenever debug is disabled.
 */
`timescale 1ns/1ps
`default_nettype none

module debug_req_holdoff import harness_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_en_i,
  input  logic debug_req_i,
  output logic debug_req_o
);

  logic [HoldoffWidth-1:0] holdoff_cnt_q;
  logic                    holdoff_done;

  assign holdoff_done = (holdoff_cnt_q == '0);

  // Reloaded only by power-on reset, a debug-module reset leaves it alone
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      holdoff_cnt_q <= HoldoffWidth'(HoldoffCycles);
    end else if (!holdoff_done) begin
      holdoff_cnt_q <= holdoff_cnt_q - 1'b1;
    end
  end

  // Combinational gate, enable acts in the same cycle
  assign debug_req_o = holdoff_done & debug_en_i & debug_req_i;

endmodule

`default_nettype wire

// File: hw/addr_decoder.sv
/*
 * System address decoder
 * Maps a request address onto one of the peripheral regions of the
 * harness address map. Result is registered, one cycle after the
 * request, with a miss flag for unmapped addresses.
 */
`timescale 1ns/1ps
`default_nettype none

module addr_decoder import harness_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    addr_valid_i,
  input  logic [SysAddrWidth-1:0] addr_i,
  output logic                    dec_valid_o,
  output periph_e                 dec_idx_o,
  output logic                    dec_miss_o
);

  periph_e idx_d;
  logic    miss_d;
  logic    dec_valid_q;
  periph_e dec_idx_q;
  logic    dec_miss_q;

  // ----------------------------------------------------------------------
  // Range compare
  // ----------------------------------------------------------------------
  // Regions are disjoint, so at most one hit; end address is exclusive
  always_comb begin
    idx_d  = DEBUG;
    miss_d = 1'b1;
    for (int unsigned i = 0; i < NumPeriph; i++) begin
      if ((addr_i >= PeriphBase[i]) && (addr_i < PeriphBase[i] + PeriphLength[i])) begin
        idx_d  = periph_e'(i);
        miss_d = 1'b0;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Output register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dec_valid_q <= 1'b0;
    end else begin
      dec_valid_q <= addr_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (addr_valid_i) begin
      dec_idx_q  <= idx_d;
      dec_miss_q <= miss_d;
    end
  end

  assign dec_valid_o = dec_valid_q;
  assign dec_idx_o   = dec_idx_q;
  assign dec_miss_o  = dec_miss_q;

endmodule

`default_nettype wire

// File: hw/reset_sync.sv
/*
 * System reset generator
 * Power-on reset or a debug-module reset request pulls the system
 * reset low at once; release is synchronized over two flops.
 */
`timescale 1ns/1ps
`default_nettype none

module reset_sync (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  output logic sys_rst_no
);

  logic       rst_comb_n;
  logic [1:0] sync_q;

  // Either source holds the system in reset
  assign rst_comb_n = rst_ni & ~ndmreset_i;

  // Assert async, release on the second edge
  always_ff @(posedge clk_i or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign sys_rst_no = sync_q[1];

endmodule

`default_nettype wire

// File: hw/harness_top.sv
/*
 * Harness control top
 * Debug transport selection, hart debug request hold-off, system
 * address decode and system reset generation of the test harness.
 */
`timescale 1ns/1ps
`default_nettype none

module harness_top import harness_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    jtag_sel_i,
  input  logic                    ndmreset_i,
  input  logic                    debug_en_i,
  input  logic                    debug_req_i,
  input  logic                    addr_valid_i,
  input  logic [SysAddrWidth-1:0] addr_i,
  // JTAG transport
  input  logic                    jtag_req_valid_i,
  input  logic [DmiAddrWidth-1:0] jtag_req_addr_i,
  input  dmi_op_e                 jtag_req_op_i,
  input  logic [DmiDataWidth-1:0] jtag_req_data_i,
  input  logic                    jtag_resp_ready_i,
  output logic                    jtag_req_ready_o,
  output logic                    jtag_resp_valid_o,
  output logic [DmiDataWidth-1:0] jtag_resp_data_o,
  output dmi_resp_e               jtag_resp_code_o,
  // DTM transport
  input  logic                    dtm_req_valid_i,
  input  logic [DmiAddrWidth-1:0] dtm_req_addr_i,
  input  dmi_op_e                 dtm_req_op_i,
  input  logic [DmiDataWidth-1:0] dtm_req_data_i,
  input  logic                    dtm_resp_ready_i,
  output logic                    dtm_req_ready_o,
  output logic                    dtm_resp_valid_o,
  output logic [DmiDataWidth-1:0] dtm_resp_data_o,
  output dmi_resp_e               dtm_resp_code_o,
  input  logic [DmiDataWidth-1:0] jtag_exit_i,
  input  logic [DmiDataWidth-1:0] dtm_exit_i,
  // Debug module
  output logic                    dm_req_valid_o,
  output logic [DmiAddrWidth-1:0] dm_req_addr_o,
  output dmi_op_e                 dm_req_op_o,
  output logic [DmiDataWidth-1:0] dm_req_data_o,
  output logic                    dm_resp_ready_o,
  input  logic                    dm_req_ready_i,
  input  logic                    dm_resp_valid_i,
  input  logic [DmiDataWidth-1:0] dm_resp_data_i,
  input  dmi_resp_e               dm_resp_code_i,
  // Status
  output logic [DmiDataWidth-1:0] exit_o,
  output logic                    debug_req_o,
  output logic                    sys_rst_no,
  output logic                    dec_valid_o,
  output periph_e                 dec_idx_o,
  output logic                    dec_miss_o
);

  dmi_if jtag_dmi ();
  dmi_if dtm_dmi ();
  dmi_if dm_dmi ();

  // ----------------------------------------------------------------------
  // Port to channel mapping
  // ----------------------------------------------------------------------
  assign jtag_dmi.req_valid  = jtag_req_valid_i;
  assign jtag_dmi.req_addr   = jtag_req_addr_i;
  assign jtag_dmi.req_op     = jtag_req_op_i;
  assign jtag_dmi.req_data   = jtag_req_data_i;
  assign jtag_dmi.resp_ready = jtag_resp_ready_i;
  assign jtag_req_ready_o    = jtag_dmi.req_ready;
  assign jtag_resp_valid_o   = jtag_dmi.resp_valid;
  assign jtag_resp_data_o    = jtag_dmi.resp_data;
  assign jtag_resp_code_o    = jtag_dmi.resp_code;

  assign dtm_dmi.req_valid  = dtm_req_valid_i;
  assign dtm_dmi.req_addr   = dtm_req_addr_i;
  assign dtm_dmi.req_op     = dtm_req_op_i;
  assign dtm_dmi.req_data   = dtm_req_data_i;
  assign dtm_dmi.resp_ready = dtm_resp_ready_i;
  assign dtm_req_ready_o    = dtm_dmi.req_ready;
  assign dtm_resp_valid_o   = dtm_dmi.resp_valid;
  assign dtm_resp_data_o    = dtm_dmi.resp_data;
  assign dtm_resp_code_o    = dtm_dmi.resp_code;

  assign dm_req_valid_o     = dm_dmi.req_valid;
  assign dm_req_addr_o      = dm_dmi.req_addr;
  assign dm_req_op_o        = dm_dmi.req_op;
  assign dm_req_data_o      = dm_dmi.req_data;
  assign dm_resp_ready_o    = dm_dmi.resp_ready;
  assign dm_dmi.req_ready   = dm_req_ready_i;
  assign dm_dmi.resp_valid  = dm_resp_valid_i;
  assign dm_dmi.resp_data   = dm_resp_data_i;
  assign dm_dmi.resp_code   = dm_resp_code_i;

  // ----------------------------------------------------------------------
  // Control blocks
  // ----------------------------------------------------------------------
  reset_sync i_reset_sync (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .ndmreset_i ( ndmreset_i ),
    .sys_rst_no ( sys_rst_no )
  );

  // Power-on reset only, so ndmreset does not restart the hold-off
  debug_req_holdoff i_debug_req_holdoff (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_en_i  ( debug_en_i  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

  dmi_source_mux i_dmi_source_mux (
    .jtag_sel_i  ( jtag_sel_i  ),
    .jtag_dmi    ( jtag_dmi    ),
    .dtm_dmi     ( dtm_dmi     ),
    .dm_dmi      ( dm_dmi      ),
    .jtag_exit_i ( jtag_exit_i ),
    .dtm_exit_i  ( dtm_exit_i  ),
    .exit_o      ( exit_o      )
  );

  addr_decoder i_addr_decoder (
    .clk_i        ( clk_i        ),
    .rst_ni       ( sys_rst_no   ),
    .addr_valid_i ( addr_valid_i ),
    .addr_i       ( addr_i       ),
    .dec_valid_o  ( dec_valid_o  ),
    .dec_idx_o    ( dec_idx_o    ),
    .dec_miss_o   ( dec_miss_o   )
  );

endmodule

`default_nettype wire

// File: include/tb_checks.svh
/*
 * Testbench checks
 * Value compare with a fatal stop on the first mismatch and bounded
 * waits on a signal level.
 */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Upper bound for any wait in clock cycles
localparam int unsigned TbWaitLimit = 2000;

int unsigned tb_checks_done = 0;

// ------------------------------------------------------------------------
// Compare
// ------------------------------------------------------------------------
task automatic check_eq(
  input string       name,
  input logic [63:0] actual,
  input logic [63:0] expected
);
  if (actual !== expected) begin
    $display("ERR %s: got 0x%0h expected 0x%0h at %0t", name, actual, expected, $time);
    $display("ERRORS FOUND");
    $fatal(1, "check %s failed", name);
  end else begin
    tb_checks_done++;
  end
endtask

// ------------------------------------------------------------------------
// Bounded waits
// ------------------------------------------------------------------------
// Returns on the first rising edge where sig equals val
task automatic wait_for(
  ref   logic        clk,
  ref   logic        sig,
  input logic        val,
  input string       name,
  input int unsigned max_cycles = TbWaitLimit
);
  int unsigned n;
  n = 0;
  while ((sig !== val) && (n < max_cycles)) begin
    @(posedge clk);
    n++;
  end
  if (sig !== val) begin
    $display("Timeout waiting for %s == %0b after %0d cycles", name, val, n);
    $display("ERRORS FOUND");
    $fatal(1, "wait on %s timed out", name);
  end
endtask

`endif

// File: tests/tb_harness_top.sv
/*
 * Harness control testbench
 * Directed tests for reset release, DMI source routing, debug request
 * hold-off, address decode and debug-module reset.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_harness_top import harness_pkg::*; ();

  `include "tb_checks.svh"

  localparam int unsigned DriveDelay  = 2;
  localparam int unsigned ResetCycles = 5;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    jtag_sel_i;
  logic                    ndmreset_i;
  logic                    debug_en_i;
  logic                    debug_req_i;
  logic                    addr_valid_i;
  logic [SysAddrWidth-1:0] addr_i;

  // JTAG transport
  logic                    jtag_req_valid_i;
  logic                    jtag_resp_ready_i;
  logic                    jtag_req_ready_o;
  logic                    jtag_resp_valid_o;
  logic [DmiAddrWidth-1:0] jtag_req_addr_i;
  dmi_op_e                 jtag_req_op_i;
  logic [DmiDataWidth-1:0] jtag_req_data_i;
  logic [DmiDataWidth-1:0] jtag_resp_data_o;
  logic [DmiDataWidth-1:0] jtag_exit_i;
  dmi_resp_e               jtag_resp_code_o;

  // DTM transport
  logic                    dtm_req_valid_i;
  logic                    dtm_resp_ready_i;
  logic                    dtm_req_ready_o;
  logic                    dtm_resp_valid_o;
  logic [DmiAddrWidth-1:0] dtm_req_addr_i;
  dmi_op_e                 dtm_req_op_i;
  logic [DmiDataWidth-1:0] dtm_req_data_i;
  logic [DmiDataWidth-1:0] dtm_resp_data_o;
  logic [DmiDataWidth-1:0] dtm_exit_i;
  dmi_resp_e               dtm_resp_code_o;

  // Debug module side
  logic                    dm_req_valid_o;
  logic                    dm_resp_ready_o;
  logic                    dm_req_ready_i;
  logic                    dm_resp_valid_i;
  logic [DmiAddrWidth-1:0] dm_req_addr_o;
  dmi_op_e                 dm_req_op_o;
  logic [DmiDataWidth-1:0] dm_req_data_o;
  logic [DmiDataWidth-1:0] dm_resp_data_i;
  dmi_resp_e               dm_resp_code_i;

  logic [DmiDataWidth-1:0] exit_o;
  logic                    debug_req_o;
  logic                    sys_rst_no;
  logic                    dec_valid_o;
  logic                    dec_miss_o;
  periph_e                 dec_idx_o;

  // Rising edges seen since power-on reset was released
  int unsigned edges_since_por = 0;

  harness_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    if (rst_ni) begin
      edges_since_por <= edges_since_por + 1;
    end
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  task automatic next_cycle();
    @(posedge clk_i);
    #(DriveDelay);
  endtask

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "%s", msg);
  endtask

  function automatic dmi_op_e random_op();
    case ($urandom_range(0, 2))
      0:       return DMI_NOP;
      1:       return DMI_READ;
      default: return DMI_WRITE;
    endcase
  endfunction

  function automatic dmi_resp_e random_code();
    case ($urandom_range(0, 2))
      0:       return DMI_SUCCESS;
      1:       return DMI_FAILED;
      default: return DMI_BUSY;
    endcase
  endfunction

  task automatic randomize_sources();
    jtag_req_addr_i = DmiAddrWidth'($urandom);
    jtag_req_op_i   = random_op();
    jtag_req_data_i = $urandom;
    jtag_exit_i     = $urandom;
    dtm_req_addr_i  = DmiAddrWidth'($urandom);
    dtm_req_op_i    = random_op();
    dtm_req_data_i  = $urandom;
    dtm_exit_i      = $urandom;
  endtask

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------
  task automatic reset_release_test();
    // Decoder must stay idle in reset even with a request pending
    addr_valid_i = 1'b1;
    for (int unsigned i = 0; i < ResetCycles; i++) begin
      @(posedge clk_i);
      #1;
      check_eq("sys_rst_no", sys_rst_no, 1'b0);
      check_eq("dec_valid_o", dec_valid_o, 1'b0);
      check_eq("debug_req_o", debug_req_o, 1'b0);
    end
    #1;
    rst_ni       = 1'b1;
    addr_valid_i = 1'b0;
    next_cycle();
    check_eq("sys_rst_no", sys_rst_no, 1'b0);
    next_cycle();
    check_eq("sys_rst_no", sys_rst_no, 1'b1);
  endtask

  // Idle source keeps valid and resp_ready busy so any leak shows up
  task automatic dmi_routing_test(input logic sel);
    int unsigned             delay;
    logic [DmiAddrWidth-1:0] exp_addr;
    dmi_op_e                 exp_op;
    logic [DmiDataWidth-1:0] exp_data;
    logic [DmiDataWidth-1:0] rdata;
    dmi_resp_e               code;
    next_cycle();
    jtag_sel_i        = sel;
    dm_req_ready_i    = 1'b0;
    dm_resp_valid_i   = 1'b0;
    randomize_sources();
    jtag_req_valid_i  = 1'b1;
    dtm_req_valid_i   = 1'b1;
    jtag_resp_ready_i = !sel;
    dtm_resp_ready_i  = sel;
    exp_addr = sel ? jtag_req_addr_i : dtm_req_addr_i;
    exp_op   = sel ? jtag_req_op_i : dtm_req_op_i;
    exp_data = sel ? jtag_req_data_i : dtm_req_data_i;
    #1;
    check_eq("exit_o", exit_o, sel ? jtag_exit_i : dtm_exit_i);
    check_eq("dm_resp_ready_o", dm_resp_ready_o, 1'b0);
    check_eq("jtag_req_ready_o", jtag_req_ready_o, 1'b0);
    check_eq("dtm_req_ready_o", dtm_req_ready_o, 1'b0);

    // Debug module accepts after a short stall
    delay = $urandom_range(1, 3);
    fork
      begin
        repeat (delay) @(posedge clk_i);
        #(DriveDelay);
        dm_req_ready_i = 1'b1;
      end
      begin
        if (sel) wait_for(clk_i, jtag_req_ready_o, 1'b1, "jtag_req_ready_o");
        else wait_for(clk_i, dtm_req_ready_o, 1'b1, "dtm_req_ready_o");
      end
    join
    #1;
    check_eq("dm_req_valid_o", dm_req_valid_o, 1'b1);
    check_eq("dm_req_addr_o", dm_req_addr_o, exp_addr);
    check_eq("dm_req_op_o", dm_req_op_o, exp_op);
    check_eq("dm_req_data_o", dm_req_data_o, exp_data);
    #1;
    if (sel) jtag_req_valid_i = 1'b0;
    else dtm_req_valid_i = 1'b0;
    dm_req_ready_i    = 1'b0;
    rdata             = $urandom;
    code              = random_code();
    dm_resp_data_i    = rdata;
    dm_resp_code_i    = code;
    jtag_resp_ready_i = sel;
    dtm_resp_ready_i  = !sel;
    #1;
    check_eq("dm_req_valid_o", dm_req_valid_o, 1'b0);
    check_eq("dm_resp_ready_o", dm_resp_ready_o, 1'b1);

    fork
      begin
        repeat (delay) @(posedge clk_i);
        #(DriveDelay);
        dm_resp_valid_i = 1'b1;
      end
      begin
        if (sel) wait_for(clk_i, jtag_resp_valid_o, 1'b1, "jtag_resp_valid_o");
        else wait_for(clk_i, dtm_resp_valid_o, 1'b1, "dtm_resp_valid_o");
      end
    join
    #1;
    check_eq("jtag_resp_valid_o", jtag_resp_valid_o, sel);
    check_eq("dtm_resp_valid_o", dtm_resp_valid_o, !sel);
    check_eq("jtag_resp_data_o", jtag_resp_data_o, rdata);
    check_eq("dtm_resp_data_o", dtm_resp_data_o, rdata);
    check_eq("jtag_resp_code_o", jtag_resp_code_o, code);
    check_eq("dtm_resp_code_o", dtm_resp_code_o, code);
    #1;
    dm_resp_valid_i   = 1'b0;
    jtag_resp_ready_i = 1'b0;
    dtm_resp_ready_i  = 1'b0;
    dtm_req_valid_i   = 1'b0;
    jtag_req_valid_i  = 1'b0;
    #1;
    check_eq("jtag_resp_valid_o", jtag_resp_valid_o, 1'b0);
    check_eq("dtm_resp_valid_o", dtm_resp_valid_o, 1'b0);
  endtask

  task automatic debug_holdoff_test();
    int unsigned n;
    n = 0;
    next_cycle();
    if (edges_since_por >= HoldoffCycles) begin
      fail_run("Hold-off test started after the hold-off had already ended");
    end else begin
      while ((edges_since_por < HoldoffCycles) && (n < HoldoffCycles + TbWaitLimit)) begin
        check_eq("debug_req_o", debug_req_o, 1'b0);
        next_cycle();
        n++;
      end
      if (edges_since_por < HoldoffCycles) begin
        fail_run("Timed out counting clock edges during the hold-off");
      end else begin
        check_eq("debug_req_o", debug_req_o, 1'b1);
        debug_en_i = 1'b0;
        #1;
        check_eq("debug_req_o", debug_req_o, 1'b0);
        next_cycle();
        debug_en_i = 1'b1;
        #1;
        check_eq("debug_req_o", debug_req_o, 1'b1);
      end
    end
  endtask

  // One request with its result a cycle later
  task automatic decode_one(
    input logic [SysAddrWidth-1:0] addr,
    input int unsigned             exp_idx,
    input logic                    exp_miss
  );
    addr_valid_i = 1'b1;
    addr_i       = addr;
    next_cycle();
    addr_valid_i = 1'b0;
    check_eq("dec_valid_o", dec_valid_o, 1'b1);
    check_eq("dec_idx_o", dec_idx_o, exp_idx);
    check_eq("dec_miss_o", dec_miss_o, exp_miss);
    next_cycle();
    check_eq("dec_valid_o", dec_valid_o, 1'b0);
  endtask

  task automatic addr_decode_test();
    logic [SysAddrWidth-1:0] offset;
    int unsigned             region;
    next_cycle();
    for (int unsigned i = 0; i < NumPeriph; i++) begin
      offset = 64'($urandom) % PeriphLength[i];
      decode_one(PeriphBase[i] + offset, i, 1'b0);
    end
    // Just past the end of DRAM
    offset = 64'($urandom) % 64'h1000_0000;
    decode_one(PeriphBase[DRAM] + PeriphLength[DRAM] + offset, DEBUG, 1'b1);

    // Back-to-back requests with valid held high
    for (int unsigned k = 0; k < 8; k++) begin
      region       = $urandom_range(0, NumPeriph - 1);
      addr_valid_i = 1'b1;
      addr_i       = PeriphBase[region] + (64'($urandom) % PeriphLength[region]);
      next_cycle();
      check_eq("dec_valid_o", dec_valid_o, 1'b1);
      check_eq("dec_idx_o", dec_idx_o, region);
      check_eq("dec_miss_o", dec_miss_o, 1'b0);
    end
    addr_valid_i = 1'b0;
    next_cycle();
    check_eq("dec_valid_o", dec_valid_o, 1'b0);
  endtask

  task automatic ndm_reset_test();
    next_cycle();
    // Request during the pulse must be dropped by the reset decoder
    ndmreset_i   = 1'b1;
    addr_valid_i = 1'b1;
    addr_i       = PeriphBase[UART];
    #1;
    check_eq("sys_rst_no", sys_rst_no, 1'b0);
    check_eq("debug_req_o", debug_req_o, 1'b1);
    next_cycle();
    ndmreset_i   = 1'b0;
    addr_valid_i = 1'b0;
    #1;
    check_eq("sys_rst_no", sys_rst_no, 1'b0);
    check_eq("dec_valid_o", dec_valid_o, 1'b0);
    next_cycle();
    check_eq("sys_rst_no", sys_rst_no, 1'b0);
    next_cycle();
    check_eq("sys_rst_no", sys_rst_no, 1'b1);
    // Hold-off counter untouched by the debug-module reset
    check_eq("debug_req_o", debug_req_o, 1'b1);
  endtask

  // ----------------------------------------------------------------------
  // Sequence
  // ----------------------------------------------------------------------
  initial begin
    void'($urandom(67908));
    rst_ni            = 1'b0;
    jtag_sel_i        = 1'b0;
    ndmreset_i        = 1'b0;
    debug_en_i        = 1'b1;
    debug_req_i       = 1'b1;
    addr_valid_i      = 1'b0;
    addr_i            = '0;
    jtag_req_valid_i  = 1'b0;
    jtag_resp_ready_i = 1'b0;
    jtag_req_addr_i   = '0;
    jtag_req_op_i     = DMI_NOP;
    jtag_req_data_i   = '0;
    jtag_exit_i       = '0;
    dtm_req_valid_i   = 1'b0;
    dtm_resp_ready_i  = 1'b0;
    dtm_req_addr_i    = '0;
    dtm_req_op_i      = DMI_NOP;
    dtm_req_data_i    = '0;
    dtm_exit_i        = '0;
    dm_req_ready_i    = 1'b0;
    dm_resp_valid_i   = 1'b0;
    dm_resp_data_i    = '0;
    dm_resp_code_i    = DMI_SUCCESS;

    reset_release_test();
    dmi_routing_test(1'b1);
    dmi_routing_test(1'b0);
    debug_holdoff_test();
    addr_decode_test();
    ndm_reset_test();

    $display("%0d checks passed", tb_checks_done);
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
hw/harness_pkg.sv
hw/dmi_if.sv
hw/dmi_source_mux.sv
hw/debug_req_holdoff.sv
hw/addr_decoder.sv
hw/reset_sync.sv
hw/harness_top.sv
tests/tb_harness_top.sv

// File: Bender.yml
package:
  name: harness_ctrl

sources:
  - files:
      - hw/harness_pkg.sv
      - hw/dmi_if.sv
      - hw/dmi_source_mux.sv
      - hw/debug_req_holdoff.sv
      - hw/addr_decoder.sv
      - hw/reset_sync.sv
      - hw/harness_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_harness_top.sv
